// File: conf_addr_decode.sv
`timescale 1ns/1ps
`default_nettype none

module conf_addr_decode (
   input  logic                               ctr_valid,
   input  logic                               ctr_we,
   input  logic [conf_pkg::conf_addr_w-1:0]   ctr_addr,
   input  logic [conf_pkg::ctrl_data_w-1:0]   ctr_data_in,
   output logic                               clr,
   output logic                               mem_we,
   output logic                               alu_we,
   output logic                               mul_we,
   output logic                               bs_we,
   output logic [conf_pkg::unit_idx_w-1:0]    unit,
   output logic [conf_pkg::field_idx_w-1:0]   field
);
   import conf_pkg::*;

   logic                   conf_we;
   logic [conf_addr_w-1:0] mem_off;
   logic [conf_addr_w-1:0] alu_off;
   logic [conf_addr_w-1:0] mul_off;
   logic [conf_addr_w-1:0] bs_off;
   logic [conf_addr_w-1:0] fu_off;
   logic                   mem_hit;
   logic                   alu_hit;
   logic                   mul_hit;
   logic                   bs_hit;

   assign conf_we = ctr_valid & ctr_we;

   // offsets wrap below the base, so one compare gives the range
   assign mem_off = ctr_addr - conf_addr_w'(mem_base);
   assign alu_off = ctr_addr - conf_addr_w'(alu_base);
   assign mul_off = ctr_addr - conf_addr_w'(mul_base);
   assign bs_off  = ctr_addr - conf_addr_w'(bs_base);

   assign mem_hit = mem_off < conf_addr_w'(n_mem*mem_stride);
   assign alu_hit = alu_off < conf_addr_w'(n_alu*fu_stride);
   assign mul_hit = mul_off < conf_addr_w'(n_mul*fu_stride);
   assign bs_hit  = bs_off < conf_addr_w'(n_bs*fu_stride);

   assign fu_off = alu_hit ? alu_off : (mul_hit ? mul_off : bs_off);

   // unit and field are shared and only the strobes pick a bank
   always_comb begin
      if (mem_hit) begin
         unit  = unit_idx_w'(mem_off / mem_stride);
         field = field_idx_w'(mem_off % mem_stride);
      end else begin
         unit  = unit_idx_w'(fu_off / fu_stride);
         field = field_idx_w'(fu_off % fu_stride);
      end
   end

   assign clr    = conf_we & (ctr_addr == conf_addr_w'(conf_clear_addr));
   assign mem_we = conf_we & mem_hit & (field <= mem_f_in_wr);
   assign alu_we = conf_we & alu_hit & (field <= fu_f_fns);
   assign mul_we = conf_we & mul_hit & (field <= fu_f_fns);
   assign bs_we  = conf_we & bs_hit & (field <= fu_f_fns);

   // a single address never selects two banks
   always_comb begin
      a_one_strobe: assert final ($onehot0({clr, mem_we, alu_we, mul_we, bs_we}))
         else $error("conf_addr_decode: overlapping strobes at address %0d", ctr_addr);
      if (mem_we | alu_we | mul_we | bs_we) begin
         a_data_known: assert final (!$isunknown(ctr_data_in))
            else $error("conf_addr_decode: unknown data on field write %0d", ctr_addr);
      end
   end

endmodule

`default_nettype wire

// File: conf_fu_bank.sv
`timescale 1ns/1ps
`default_nettype none

module conf_fu_bank #(
   parameter int  n_units = 2,
   parameter type fns_t   = logic [1:0]
) (
   input  logic                                                   clk,
   input  logic                                                   rst,
   input  logic                                                   clr,
   input  logic                                                   ld,
   input  logic [n_units*(2*conf_pkg::sel_w+$bits(fns_t))-1:0]    ld_data,
   input  logic                                                   we,
   input  logic [conf_pkg::unit_idx_w-1:0]                        unit,
   input  logic [conf_pkg::field_idx_w-1:0]                       field,
   input  logic [conf_pkg::ctrl_data_w-1:0]                       data,
   output logic [n_units*(2*conf_pkg::sel_w+$bits(fns_t))-1:0]    conf
);
   import conf_pkg::*;

   localparam int fns_w   = $bits(fns_t);
   localparam int slice_w = 2*sel_w + fns_w;

   logic [sel_w-1:0] sela [n_units];
   logic [sel_w-1:0] selb [n_units];
   fns_t             fns  [n_units];

   // same priority as the memory bank
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < n_units; i++) begin
            sela[i] <= '0;
            selb[i] <= '0;
            fns[i]  <= '0;
         end
      end else if (ld) begin
         for (int i = 0; i < n_units; i++) begin
            {sela[i], selb[i], fns[i]} <= ld_data[(n_units-i)*slice_w-1 -: slice_w];
         end
      end else if (clr) begin
         for (int i = 0; i < n_units; i++) begin
            sela[i] <= '0;
            selb[i] <= '0;
            fns[i]  <= '0;
         end
      end else if (we) begin
         for (int i = 0; i < n_units; i++) begin
            if (int'(unit) == i) begin
               case (field)
                  fu_f_sela: sela[i] <= data[sel_w-1:0];
                  fu_f_selb: selb[i] <= data[sel_w-1:0];
                  fu_f_fns:  fns[i]  <= fns_t'(data[fns_w-1:0]);
                  default: ;
               endcase
            end
         end
      end
   end

   for (genvar g = 0; g < n_units; g++) begin : g_slice
      assign conf[(n_units-g)*slice_w-1 -: slice_w] = {sela[g], selb[g], fns[g]};
   end

   // catches a decoder range that is wider than this bank
   a_unit_range: assert property (@(posedge clk) disable iff (rst)
      we |-> int'(unit) < n_units)
      else $error("conf_fu_bank: write to unit %0d of %0d", unit, n_units);

endmodule

`default_nettype wire

// File: conf_mem_bank.sv
`timescale 1ns/1ps
`default_nettype none

module conf_mem_bank (
   input  logic                                 clk,
   input  logic                                 rst,
   input  logic                                 clr,
   input  logic                                 ld,
   input  logic [conf_pkg::mem_bank_bits-1:0]   ld_data,
   input  logic                                 we,
   input  logic [conf_pkg::unit_idx_w-1:0]      unit,
   input  logic [conf_pkg::field_idx_w-1:0]     field,
   input  logic [conf_pkg::ctrl_data_w-1:0]     data,
   output logic [conf_pkg::mem_bank_bits-1:0]   conf
);
   import conf_pkg::*;

   logic [mem_addr_w-1:0] iter  [n_mem];
   logic [period_w-1:0]   per   [n_mem];
   logic [period_w-1:0]   duty  [n_mem];
   logic [sel_w-1:0]      sel   [n_mem];
   logic [mem_addr_w-1:0] start [n_mem];
   logic [mem_addr_w-1:0] shift [n_mem];
   logic [mem_addr_w-1:0] incr  [n_mem];
   logic [period_w-1:0]   delay [n_mem];
   logic                  ext   [n_mem];
   logic                  in_wr [n_mem];

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         for (int i = 0; i < n_mem; i++) begin
            iter[i]  <= '0;
            per[i]   <= '0;
            duty[i]  <= '0;
            sel[i]   <= '0;
            start[i] <= '0;
            shift[i] <= '0;
            incr[i]  <= '0;
            delay[i] <= '0;
            ext[i]   <= 1'b0;
            in_wr[i] <= 1'b0;
         end
      end else if (ld) begin
         // whole word from the config memory
         for (int i = 0; i < n_mem; i++) begin
            {iter[i], per[i], duty[i], sel[i], start[i],
             shift[i], incr[i], delay[i], ext[i], in_wr[i]}
               <= ld_data[(n_mem-i)*mem_conf_bits-1 -: mem_conf_bits];
         end
      end else if (clr) begin
         for (int i = 0; i < n_mem; i++) begin
            iter[i]  <= '0;
            per[i]   <= '0;
            duty[i]  <= '0;
            sel[i]   <= '0;
            start[i] <= '0;
            shift[i] <= '0;
            incr[i]  <= '0;
            delay[i] <= '0;
            ext[i]   <= 1'b0;
            in_wr[i] <= 1'b0;
         end
      end else if (we) begin
         for (int i = 0; i < n_mem; i++) begin
            if (int'(unit) == i) begin
               // upper data bits dropped
               case (field)
                  mem_f_iter:  iter[i]  <= data[mem_addr_w-1:0];
                  mem_f_per:   per[i]   <= data[period_w-1:0];
                  mem_f_duty:  duty[i]  <= data[period_w-1:0];
                  mem_f_sel:   sel[i]   <= data[sel_w-1:0];
                  mem_f_start: start[i] <= data[mem_addr_w-1:0];
                  mem_f_shift: shift[i] <= data[mem_addr_w-1:0];
                  mem_f_incr:  incr[i]  <= data[mem_addr_w-1:0];
                  mem_f_delay: delay[i] <= data[period_w-1:0];
                  mem_f_ext:   ext[i]   <= data[0];
                  mem_f_in_wr: in_wr[i] <= data[0];
                  default: ;
               endcase
            end
         end
      end
   end

   // unit 0 in the top slice
   for (genvar g = 0; g < n_mem; g++) begin : g_slice
      assign conf[(n_mem-g)*mem_conf_bits-1 -: mem_conf_bits] =
         {iter[g], per[g], duty[g], sel[g], start[g],
          shift[g], incr[g], delay[g], ext[g], in_wr[g]};
   end

   // decoder only strobes this bank for an existing unit and field
   a_unit_range: assert property (@(posedge clk) disable iff (rst)
      we |-> int'(unit) < n_mem)
      else $error("conf_mem_bank: write to unit %0d", unit);

   a_field_range: assert property (@(posedge clk) disable iff (rst)
      we |-> field <= mem_f_in_wr)
      else $error("conf_mem_bank: write to field %0d", field);

endmodule

`default_nettype wire

// File: conf_pkg.sv
`default_nettype none

package conf_pkg;

   // control port
   localparam int ctrl_data_w = 32;
   localparam int conf_addr_w = 7;

   // datapath field widths
   localparam int sel_w      = 5;
   localparam int mem_addr_w = 10;
   localparam int period_w   = 5;

   // unit counts
   localparam int n_mem = 2;
   localparam int n_alu = 2;
   localparam int n_mul = 2;
   localparam int n_bs  = 1;

   // function selects
   typedef logic [3:0] alu_fns_t;
   typedef logic [1:0] mul_fns_t;
   typedef logic [1:0] bs_fns_t;

   // address map
   localparam int mem_base        = 0;
   localparam int mem_stride      = 16;
   localparam int alu_base        = 32;
   localparam int mul_base        = 40;
   localparam int bs_base         = 48;
   localparam int fu_stride       = 4;
   localparam int conf_clear_addr = 127;

   localparam int unit_idx_w  = 1;
   localparam int field_idx_w = 4;

   // memory unit fields in packing order from the top
   localparam logic [field_idx_w-1:0] mem_f_iter  = 4'd0;
   localparam logic [field_idx_w-1:0] mem_f_per   = 4'd1;
   localparam logic [field_idx_w-1:0] mem_f_duty  = 4'd2;
   localparam logic [field_idx_w-1:0] mem_f_sel   = 4'd3;
   localparam logic [field_idx_w-1:0] mem_f_start = 4'd4;
   localparam logic [field_idx_w-1:0] mem_f_shift = 4'd5;
   localparam logic [field_idx_w-1:0] mem_f_incr  = 4'd6;
   localparam logic [field_idx_w-1:0] mem_f_delay = 4'd7;
   localparam logic [field_idx_w-1:0] mem_f_ext   = 4'd8;
   localparam logic [field_idx_w-1:0] mem_f_in_wr = 4'd9;

   // alu, mul and bs share this layout
   localparam logic [field_idx_w-1:0] fu_f_sela = 4'd0;
   localparam logic [field_idx_w-1:0] fu_f_selb = 4'd1;
   localparam logic [field_idx_w-1:0] fu_f_fns  = 4'd2;

   // per-unit slice widths
   localparam int mem_conf_bits = 4*mem_addr_w + 3*period_w + sel_w + 2;
   localparam int alu_conf_bits = 2*sel_w + $bits(alu_fns_t);
   localparam int mul_conf_bits = 2*sel_w + $bits(mul_fns_t);
   localparam int bs_conf_bits  = 2*sel_w + $bits(bs_fns_t);

   // per-bank slice widths
   localparam int mem_bank_bits = n_mem*mem_conf_bits;
   localparam int alu_bank_bits = n_alu*alu_conf_bits;
   localparam int mul_bank_bits = n_mul*mul_conf_bits;
   localparam int bs_bank_bits  = n_bs*bs_conf_bits;

   localparam int conf_bits = mem_bank_bits + alu_bank_bits + mul_bank_bits + bs_bank_bits;

   // bank positions in the flat word with mem on top
   localparam int bs_lsb  = 0;
   localparam int mul_lsb = bs_lsb + bs_bank_bits;
   localparam int alu_lsb = mul_lsb + mul_bank_bits;
   localparam int mem_lsb = alu_lsb + alu_bank_bits;

endpackage

`default_nettype wire

// File: conf_reg.sv
`timescale 1ns/1ps
`default_nettype none

module conf_reg (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               ctr_valid,
   input  logic                               ctr_we,
   input  logic [conf_pkg::conf_addr_w-1:0]   ctr_addr,
   input  logic [conf_pkg::ctrl_data_w-1:0]   ctr_data_in,
   input  logic                               conf_ld,
   input  logic [conf_pkg::conf_bits-1:0]     conf_in,
   output logic [conf_pkg::conf_bits-1:0]     conf_out
);
   import conf_pkg::*;

   logic                   clr;
   logic                   mem_we;
   logic                   alu_we;
   logic                   mul_we;
   logic                   bs_we;
   logic [unit_idx_w-1:0]  unit;
   logic [field_idx_w-1:0] field;

   conf_addr_decode u_dec (
      .ctr_valid   (ctr_valid),
      .ctr_we      (ctr_we),
      .ctr_addr    (ctr_addr),
      .ctr_data_in (ctr_data_in),
      .clr         (clr),
      .mem_we      (mem_we),
      .alu_we      (alu_we),
      .mul_we      (mul_we),
      .bs_we       (bs_we),
      .unit        (unit),
      .field       (field)
   );

   // each bank owns one slice of the flat word
   conf_mem_bank u_mem (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .ld      (conf_ld),
      .ld_data (conf_in[mem_lsb +: mem_bank_bits]),
      .we      (mem_we),
      .unit    (unit),
      .field   (field),
      .data    (ctr_data_in),
      .conf    (conf_out[mem_lsb +: mem_bank_bits])
   );

   conf_fu_bank #(.n_units(n_alu), .fns_t(alu_fns_t)) u_alu (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .ld      (conf_ld),
      .ld_data (conf_in[alu_lsb +: alu_bank_bits]),
      .we      (alu_we),
      .unit    (unit),
      .field   (field),
      .data    (ctr_data_in),
      .conf    (conf_out[alu_lsb +: alu_bank_bits])
   );

   conf_fu_bank #(.n_units(n_mul), .fns_t(mul_fns_t)) u_mul (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .ld      (conf_ld),
      .ld_data (conf_in[mul_lsb +: mul_bank_bits]),
      .we      (mul_we),
      .unit    (unit),
      .field   (field),
      .data    (ctr_data_in),
      .conf    (conf_out[mul_lsb +: mul_bank_bits])
   );

   // sela and selb of the barrel shifter carry data and shift amount
   conf_fu_bank #(.n_units(n_bs), .fns_t(bs_fns_t)) u_bs (
      .clk     (clk),
      .rst     (rst),
      .clr     (clr),
      .ld      (conf_ld),
      .ld_data (conf_in[bs_lsb +: bs_bank_bits]),
      .we      (bs_we),
      .unit    (unit),
      .field   (field),
      .data    (ctr_data_in),
      .conf    (conf_out[bs_lsb +: bs_bank_bits])
   );

endmodule

`default_nettype wire

// File: conf_reg_checker.sv
`timescale 1ns/1ps
`default_nettype none

module conf_reg_checker (
   input  logic                               clk,
   input  logic                               rst,
   input  logic                               ctr_valid,
   input  logic                               ctr_we,
   input  logic [conf_pkg::conf_addr_w-1:0]   ctr_addr,
   input  logic [conf_pkg::ctrl_data_w-1:0]   ctr_data_in,
   input  logic                               conf_ld,
   input  logic [conf_pkg::conf_bits-1:0]     conf_in,
   input  logic [conf_pkg::conf_bits-1:0]     conf_out,
   output int                                 errors,
   output int                                 checks
);
   import conf_pkg::*;

   localparam int n_mem_fields = 10;
   localparam int n_fu_fields  = 3;
   localparam int n_fields     = n_mem*n_mem_fields + (n_alu+n_mul+n_bs)*n_fu_fields;

   logic [conf_bits-1:0] model;
   logic                 armed;

   function automatic int mem_field_w(input int f);
      case (f)
         0, 4, 5, 6: return mem_addr_w;
         1, 2, 7:    return period_w;
         3:          return sel_w;
         default:    return 1;
      endcase
   endfunction

   function automatic string mem_field_name(input int f);
      case (f)
         0:       return "iter";
         1:       return "per";
         2:       return "duty";
         3:       return "sel";
         4:       return "start";
         5:       return "shift";
         6:       return "incr";
         7:       return "delay";
         8:       return "ext";
         default: return "in_wr";
      endcase
   endfunction

   // fu units counted alu0, alu1, mul0, mul1, bs0
   function automatic int fu_fns_w(input int u);
      if (u < n_alu) return $bits(alu_fns_t);
      if (u < n_alu + n_mul) return $bits(mul_fns_t);
      return $bits(bs_fns_t);
   endfunction

   function automatic string fu_unit_name(input int u);
      if (u < n_alu) return $sformatf("alu%0d", u);
      if (u < n_alu + n_mul) return $sformatf("mul%0d", u - n_alu);
      return $sformatf("bs%0d", u - n_alu - n_mul);
   endfunction

   // position of field k in the flat word with units packed from the top
   function automatic void field_info(input int k, output string name,
                                      output int lsb, output int w);
      int u;
      int f;
      int top;
      if (k < n_mem*n_mem_fields) begin
         u   = k / n_mem_fields;
         f   = k % n_mem_fields;
         top = conf_bits - u*mem_conf_bits;
         for (int i = 0; i <= f; i++) top -= mem_field_w(i);
         lsb  = top;
         w    = mem_field_w(f);
         name = $sformatf("mem%0d.%s", u, mem_field_name(f));
      end else begin
         u   = (k - n_mem*n_mem_fields) / n_fu_fields;
         f   = (k - n_mem*n_mem_fields) % n_fu_fields;
         top = conf_bits - n_mem*mem_conf_bits;
         for (int i = 0; i < u; i++) top -= 2*sel_w + fu_fns_w(i);
         if (f == 0) begin
            lsb  = top - sel_w;
            w    = sel_w;
            name = {fu_unit_name(u), ".sela"};
         end else if (f == 1) begin
            lsb  = top - 2*sel_w;
            w    = sel_w;
            name = {fu_unit_name(u), ".selb"};
         end else begin
            w    = fu_fns_w(u);
            lsb  = top - 2*sel_w - w;
            name = {fu_unit_name(u), ".fns"};
         end
      end
   endfunction

   // -1 for unmapped addresses and illegal field indices
   function automatic int addr_to_field(input logic [conf_addr_w-1:0] addr);
      int a;
      int off;
      a = addr;
      if (a >= mem_base && a < mem_base + n_mem*mem_stride) begin
         off = a - mem_base;
         if (off % mem_stride < n_mem_fields)
            return (off / mem_stride)*n_mem_fields + off % mem_stride;
      end else if (a >= alu_base && a < alu_base + n_alu*fu_stride) begin
         off = a - alu_base;
         if (off % fu_stride < n_fu_fields)
            return n_mem*n_mem_fields + (off / fu_stride)*n_fu_fields + off % fu_stride;
      end else if (a >= mul_base && a < mul_base + n_mul*fu_stride) begin
         off = a - mul_base;
         if (off % fu_stride < n_fu_fields)
            return n_mem*n_mem_fields + (n_alu + off / fu_stride)*n_fu_fields
                   + off % fu_stride;
      end else if (a >= bs_base && a < bs_base + n_bs*fu_stride) begin
         off = a - bs_base;
         if (off % fu_stride < n_fu_fields)
            return n_mem*n_mem_fields + (n_alu + n_mul + off / fu_stride)*n_fu_fields
                   + off % fu_stride;
      end
      return -1;
   endfunction

   initial begin
      model  = '0;
      armed  = 1'b0;
      errors = 0;
      checks = 0;
   end

   // load beats clear, clear beats a field write
   always @(posedge clk or posedge rst) begin : p_model
      int    k;
      string name;
      int    lsb;
      int    w;
      if (rst) begin
         model = '0;
      end else if (conf_ld) begin
         model = conf_in;
      end else if (ctr_valid && ctr_we) begin
         if (ctr_addr == conf_addr_w'(conf_clear_addr)) begin
            model = '0;
         end else begin
            k = addr_to_field(ctr_addr);
            if (k >= 0) begin
               field_info(k, name, lsb, w);
               for (int b = 0; b < w; b++) model[lsb+b] = ctr_data_in[b];
            end
         end
      end
   end

   // comparing starts at the first rising edge out of reset
   always @(posedge clk or posedge rst) begin : p_arm
      if (rst) begin
         armed <= 1'b0;
      end else begin
         armed <= 1'b1;
      end
   end

   // conf_out has settled half a cycle after the edge
   always @(negedge clk) begin : p_compare
      string       name;
      int          lsb;
      int          w;
      logic [31:0] exp_v;
      logic [31:0] got_v;
      if (armed) begin
         for (int k = 0; k < n_fields; k++) begin
            field_info(k, name, lsb, w);
            exp_v = '0;
            got_v = '0;
            for (int b = 0; b < w; b++) begin
               exp_v[b] = model[lsb+b];
               got_v[b] = conf_out[lsb+b];
            end
            checks++;
            if (got_v !== exp_v) begin
               errors++;
               $display("Error at %0t ns: %s expected 0x%0h, got 0x%0h",
                        $time, name, exp_v, got_v);
            end
         end
      end
   end

endmodule

`default_nettype wire

// File: conf_reg_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conf_reg_tb;
   import conf_pkg::*;

   localparam int clk_period       = 20;
   localparam int reset_cycles     = 16;
   localparam int n_rand_writes    = 300;
   localparam int n_bad_writes     = 60;
   localparam int n_rebuild_writes = 40;
   localparam int n_loads          = 20;
   localparam int n_fields         = n_mem*10 + (n_alu+n_mul+n_bs)*3;
   localparam int test_cycles      = reset_cycles + 5 + (n_rand_writes + 3)
                                     + (n_bad_writes + 3) + (n_rebuild_writes + 4)
                                     + (2*n_loads + 3);
   localparam int timeout_ns       = test_cycles*clk_period + 2000;

   logic                   clk;
   logic                   rst;
   logic                   ctr_valid;
   logic                   ctr_we;
   logic [conf_addr_w-1:0] ctr_addr;
   logic [ctrl_data_w-1:0] ctr_data_in;
   logic                   conf_ld;
   logic [conf_bits-1:0]   conf_in;
   logic [conf_bits-1:0]   conf_out;
   int                     errors;
   int                     checks;
   int                     tests_run;
   int                     tests_failed;
   int                     errs_at_start;

   tb_clock #(.period(clk_period)) u_clk (.clk(clk));

   conf_reg UUT (
      .clk         (clk),
      .rst         (rst),
      .ctr_valid   (ctr_valid),
      .ctr_we      (ctr_we),
      .ctr_addr    (ctr_addr),
      .ctr_data_in (ctr_data_in),
      .conf_ld     (conf_ld),
      .conf_in     (conf_in),
      .conf_out    (conf_out)
   );

   conf_reg_checker u_chk (
      .clk         (clk),
      .rst         (rst),
      .ctr_valid   (ctr_valid),
      .ctr_we      (ctr_we),
      .ctr_addr    (ctr_addr),
      .ctr_data_in (ctr_data_in),
      .conf_ld     (conf_ld),
      .conf_in     (conf_in),
      .conf_out    (conf_out),
      .errors      (errors),
      .checks      (checks)
   );

   // one cycle of stimulus set up on the falling edge
   task automatic drive(input logic valid, input logic we, input logic [conf_addr_w-1:0] addr,
                        input logic [ctrl_data_w-1:0] data, input logic ld,
                        input logic [conf_bits-1:0] ld_word);
      @(negedge clk);
      ctr_valid   = valid;
      ctr_we      = we;
      ctr_addr    = addr;
      ctr_data_in = data;
      conf_ld     = ld;
      conf_in     = ld_word;
   endtask

   task automatic idle(input int n);
      repeat (n) drive(1'b0, 1'b0, '0, '0, 1'b0, '0);
   endtask

   function automatic logic [conf_addr_w-1:0] legal_addr(input int k);
      int u;
      int f;
      if (k < n_mem*10) return conf_addr_w'(mem_base + (k/10)*mem_stride + k%10);
      u = (k - n_mem*10) / 3;
      f = (k - n_mem*10) % 3;
      if (u < n_alu) return conf_addr_w'(alu_base + u*fu_stride + f);
      if (u < n_alu + n_mul) return conf_addr_w'(mul_base + (u - n_alu)*fu_stride + f);
      return conf_addr_w'(bs_base + (u - n_alu - n_mul)*fu_stride + f);
   endfunction

   function automatic logic [conf_bits-1:0] random_word();
      logic [conf_bits-1:0] w;
      w = '0;
      for (int i = 0; i < conf_bits; i += 32) w = (w << 32) | conf_bits'($urandom());
      return w;
   endfunction

   task automatic random_write();
      drive(1'b1, 1'b1, legal_addr($urandom_range(0, n_fields-1)), $urandom(), 1'b0, '0);
   endtask

   task automatic end_test(input string name);
      idle(2);
      @(posedge clk);
      tests_run++;
      if (errors == errs_at_start) begin
         $display("test %0d %s: passed", tests_run, name);
      end else begin
         tests_failed++;
         $display("test %0d %s: %0d errors", tests_run, name, errors - errs_at_start);
      end
      errs_at_start = errors;
   endtask

   initial begin
      rst           = 1'b1;
      ctr_valid     = 1'b0;
      ctr_we        = 1'b0;
      ctr_addr      = '0;
      ctr_data_in   = '0;
      conf_ld       = 1'b0;
      conf_in       = '0;
      tests_run     = 0;
      tests_failed  = 0;
      errs_at_start = 0;
      void'($urandom(32'h04a44503));
      repeat (reset_cycles) @(negedge clk);
      rst = 1'b0;
      idle(1);
      end_test("reset value");

      repeat (n_rand_writes) random_write();
      end_test("random field writes");

      // none of these may touch the word
      repeat (n_bad_writes) begin
         case ($urandom_range(0, 4))
            0: drive(1'b0, 1'b1, legal_addr($urandom_range(0, n_fields-1)), $urandom(), 1'b0, '0);
            1: drive(1'b1, 1'b0, conf_addr_w'(conf_clear_addr), $urandom(), 1'b0, '0);
            2: drive(1'b1, 1'b1, conf_addr_w'($urandom_range(52, 126)), $urandom(), 1'b0, '0);
            3: drive(1'b1, 1'b1, conf_addr_w'($urandom_range(0, 1)*mem_stride
                     + $urandom_range(10, 15)), $urandom(), 1'b0, '0);
            default: drive(1'b1, 1'b1, conf_addr_w'(alu_base + 4*$urandom_range(0, 4) + 3),
                           $urandom(), 1'b0, '0);
         endcase
      end
      end_test("ignored writes");

      drive(1'b1, 1'b1, conf_addr_w'(conf_clear_addr), $urandom(), 1'b0, '0);
      repeat (n_rebuild_writes) random_write();
      end_test("clear and rebuild");

      // a control write next to each load must lose
      repeat (n_loads) begin
         case ($urandom_range(0, 2))
            0: drive(1'b0, 1'b0, '0, '0, 1'b1, random_word());
            1: drive(1'b1, 1'b1, legal_addr($urandom_range(0, n_fields-1)), $urandom(),
                     1'b1, random_word());
            default: drive(1'b1, 1'b1, conf_addr_w'(conf_clear_addr), $urandom(),
                           1'b1, random_word());
         endcase
         random_write();
      end
      end_test("word load priority");

      $display("tests run %0d, failed %0d, field checks %0d, errors %0d",
               tests_run, tests_failed, checks, errors);
      if (tests_failed == 0 && errors == 0) begin
         $display("All tests passed!");
      end else begin
         $display("Test failures found");
      end
      $finish;
   end

   initial begin
      #(timeout_ns);
      $display("watchdog: run did not complete within %0d ns", timeout_ns);
      $display("Test failures found");
      $finish;
   end

endmodule

`default_nettype wire

// File: filelist.f
conf_pkg.sv
conf_addr_decode.sv
conf_mem_bank.sv
conf_fu_bank.sv
conf_reg.sv
tb_clock.sv
conf_reg_checker.sv
conf_reg_tb.sv

// File: tb_clock.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clock #(
   parameter int period = 20
) (
   output logic clk
);

   initial begin
      clk = 1'b0;
   end

   // first rising edge at half a period
   always begin
      #(period/2) clk = ~clk;
   end

endmodule

`default_nettype wire
